// File: files.f
+incdir+logic
logic/dc302_pkg.sv
logic/dc_pipe_stage.sv
logic/dc_regfile.sv
logic/dc_micro_decode.sv
logic/dc_carry_adder.sv
logic/dc_execute.sv
logic/dc302_datapath.sv
test/tb_dc302.sv

// File: logic/dc302_datapath.sv
// DC302 pipelined data path top level
// decode and operand read, then execute with writeback, then result

`timescale 1ns/1ps

module dc302_datapath
(
   input  logic               pin_clk,
   input  logic               rst_n,
   input  dc302_pkg::dc_req_t req,
   input  logic               req_valid,
   output logic               req_ready,
   output dc302_pkg::result_t res,
   output logic               res_valid,
   input  logic               res_ready
);

   import dc302_pkg::*;

   reg_sel_t sel_a;
   reg_sel_t sel_b;
   word_t    opnd_a;
   word_t    opnd_b;
   word_t    psw;
   exec_t    dec_ctl;     // into exec_stage
   exec_t    exec_ctl;    // held in exec_stage
   logic     exec_valid;
   logic     exec_ready;  // out_stage can take
   wb_t      wb;
   result_t  exec_res;

   dc_regfile regfile_inst
   (
      .pin_clk (pin_clk),
      .rst_n   (rst_n),
      .sel_a   (sel_a),
      .sel_b   (sel_b),
      .opnd_a  (opnd_a),
      .opnd_b  (opnd_b),
      .psw     (psw),
      .wb      (wb),
      .wb_take (exec_valid & exec_ready)   // commits as the item moves on
   );

   dc_micro_decode decode_inst
   (
      .pin_clk (pin_clk),
      .rst_n   (rst_n),
      .req     (req),
      .take    (req_valid & req_ready),
      .sel_a   (sel_a),
      .sel_b   (sel_b),
      .opnd_a  (opnd_a),
      .opnd_b  (opnd_b),
      .ctl     (dec_ctl)
   );

   dc_pipe_stage #(.T(exec_t)) exec_stage
   (
      .pin_clk   (pin_clk),
      .rst_n     (rst_n),
      .in_data   (dec_ctl),
      .in_valid  (req_valid),
      .in_ready  (req_ready),
      .out_data  (exec_ctl),
      .out_valid (exec_valid),
      .out_ready (exec_ready)
   );

   dc_execute execute_inst
   (
      .ctl   (exec_ctl),
      .psw   (psw),
      .valid (exec_valid),
      .wb    (wb),
      .res   (exec_res)
   );

   dc_pipe_stage #(.T(result_t)) out_stage
   (
      .pin_clk   (pin_clk),
      .rst_n     (rst_n),
      .in_data   (exec_res),
      .in_valid  (exec_valid),
      .in_ready  (exec_ready),
      .out_data  (res),
      .out_valid (res_valid),
      .out_ready (res_ready)
   );

endmodule

// File: logic/dc302_macros.svh
// DC302 data path constants
// widths, register indices and reset values

`ifndef DC302_MACROS_SVH
`define DC302_MACROS_SVH

// data word and register file geometry
`define DC_WORD_W      16
`define DC_REG_N       16

`define DC_PSW_REG     8      // processor status word slot

// indirect select codes through the IR
`define DC_SEL_IR_SRC  12     // IR bits 8..6
`define DC_SEL_IR_DST  13     // IR bits 2..0

// register reset values
`define DC_REG_RESET   16'hFFFF
`define DC_PSW_RESET   16'hF8FF

`endif

// File: logic/dc302_pkg.sv
// DC302 data path types
// opcodes, microinstruction layout, pipeline and writeback words

`include "dc302_macros.svh"

package dc302_pkg;

   typedef logic [`DC_WORD_W-1:0]        word_t;
   typedef logic [$clog2(`DC_REG_N)-1:0] reg_sel_t;

   typedef enum logic [3:0]
   {
      op_mov  = 4'd0,    // dst = b
      op_add  = 4'd1,
      op_sub  = 4'd2,
      op_and  = 4'd3,
      op_bic  = 4'd4,    // a & ~b
      op_bis  = 4'd5,    // a | b
      op_xor  = 4'd6,
      op_asr  = 4'd7,    // b >>> 1
      op_ldx  = 4'd8,    // dst = external data
      op_ldir = 4'd9,    // ir = external data
      op_addi = 4'd10,   // a + 8-bit immediate
      op_tst  = 4'd11    // flags only
   } dc_op_t;

   typedef struct packed
   {
      dc_op_t     op;
      logic [3:0] cond;    // also immediate low nibble
      reg_sel_t   sel_b;   // also immediate high nibble
      reg_sel_t   sel_a;   // source a and destination
   } uinstr_t;

   typedef struct packed
   {
      uinstr_t ui;
      word_t   data;
   } dc_req_t;

   // same bit order as psw[3:0]
   typedef struct packed
   {
      logic n;
      logic z;
      logic v;
      logic c;
   } flags_t;

   typedef struct packed
   {
      dc_op_t     op;
      logic [3:0] cond;
      word_t      opnd_a;
      word_t      opnd_b;
      reg_sel_t   dst;
      word_t      data;
   } exec_t;

   typedef struct packed
   {
      logic     we;      // data write
      reg_sel_t dst;
      word_t    data;
      logic     fe;      // flag write
      flags_t   flags;
   } wb_t;

   typedef struct packed
   {
      word_t    data;
      flags_t   flags;
      logic     branch;
      reg_sel_t dst;
   } result_t;

endpackage

// File: logic/dc_carry_adder.sv
// 16-bit adder with look-ahead carry in nibble groups
// exposes the carries into and out of bit 15 for overflow

`timescale 1ns/1ps
`include "dc302_macros.svh"

module dc_carry_adder
(
   input  dc302_pkg::word_t x,
   input  dc302_pkg::word_t y,
   input  logic             cin,
   output dc302_pkg::word_t sum,
   output logic             cout,
   output logic             c15
);

   import dc302_pkg::*;

   word_t               g;   // generate
   word_t               p;   // propagate
   logic [`DC_WORD_W:0] c;   // carry into each bit

   assign g    = x & y;
   assign p    = x ^ y;
   assign c[0] = cin;

   // each nibble looks ahead from its own carry in, groups ripple
   for (genvar k = 0; k < `DC_WORD_W; k = k + 4)
   begin : gen_nibble
      assign c[k+1] = g[k]
                    | p[k] & c[k];
      assign c[k+2] = g[k+1]
                    | p[k+1] & g[k]
                    | p[k+1] & p[k] & c[k];
      assign c[k+3] = g[k+2]
                    | p[k+2] & g[k+1]
                    | p[k+2] & p[k+1] & g[k]
                    | p[k+2] & p[k+1] & p[k] & c[k];
      assign c[k+4] = g[k+3]
                    | p[k+3] & g[k+2]
                    | p[k+3] & p[k+2] & g[k+1]
                    | p[k+3] & p[k+2] & p[k+1] & g[k]
                    | p[k+3] & p[k+2] & p[k+1] & p[k] & c[k];
   end

   assign sum  = p ^ c[`DC_WORD_W-1:0];
   assign cout = c[`DC_WORD_W];
   assign c15  = c[`DC_WORD_W-1];

endmodule

// File: logic/dc_execute.sv
// DC302 execute stage
// ALU functions, N/Z/V/C flags, branch test and writeback word

`timescale 1ns/1ps

module dc_execute
(
   input  dc302_pkg::exec_t   ctl,
   input  dc302_pkg::word_t   psw,
   input  logic               valid,
   output dc302_pkg::wb_t     wb,
   output dc302_pkg::result_t res
);

   import dc302_pkg::*;

   logic   sub;
   word_t  b_in;     // adder port b
   word_t  sum;
   logic   cout;
   logic   c15;
   word_t  data;
   flags_t old_f;
   flags_t new_f;
   logic   branch;

   assign sub   = ctl.op == op_sub;
   assign b_in  = sub ? ~ctl.opnd_b : ctl.opnd_b;   // a + ~b + 1
   assign old_f = flags_t'(psw[3:0]);

   dc_carry_adder adder_inst
   (
      .x    (ctl.opnd_a),
      .y    (b_in),
      .cin  (sub),
      .sum  (sum),
      .cout (cout),
      .c15  (c15)
   );

   always_comb
   begin
      case (ctl.op)
         op_mov:  data = ctl.opnd_b;
         op_add,
         op_addi,
         op_sub:  data = sum;
         op_and:  data = ctl.opnd_a & ctl.opnd_b;
         op_bic:  data = ctl.opnd_a & ~ctl.opnd_b;
         op_bis:  data = ctl.opnd_a | ctl.opnd_b;
         op_xor:  data = ctl.opnd_a ^ ctl.opnd_b;
         op_asr:  data = {ctl.opnd_b[15], ctl.opnd_b[15:1]};
         op_ldx,
         op_ldir: data = ctl.data;
         default: data = ctl.opnd_a;   // tst and unused codes
      endcase

      new_f.n = data[15];
      new_f.z = data == '0;
      new_f.v = 1'b0;
      new_f.c = old_f.c;     // kept by logic ops

      case (ctl.op)
         op_add,
         op_addi:
         begin
            new_f.c = cout;
            new_f.v = c15 ^ cout;
         end
         op_sub:
         begin
            new_f.c = ~cout;   // borrow
            new_f.v = c15 ^ cout;
         end
         op_asr:
         begin
            new_f.c = ctl.opnd_b[0];
            new_f.v = data[15] ^ ctl.opnd_b[0];
         end
         default: ;
      endcase
   end

   // microinstruction branch condition
   always_comb
   begin
      case (ctl.cond[2:0])
         3'd0:    branch = new_f.n;
         3'd1:    branch = new_f.z;
         3'd2:    branch = new_f.c;
         3'd3:    branch = new_f.v;
         3'd4:    branch = old_f.n;
         3'd5:    branch = old_f.z;
         3'd6:    branch = old_f.c;
         default: branch = 1'b1;
      endcase
   end

   always_comb
   begin
      wb.we    = valid && ctl.op != op_ldir && ctl.op != op_tst;
      wb.dst   = ctl.dst;
      wb.data  = data;
      wb.fe    = valid && ctl.op != op_ldir;
      wb.flags = new_f;

      res.data   = data;
      res.flags  = new_f;
      res.branch = branch;
      res.dst    = ctl.dst;
   end

endmodule

// File: logic/dc_micro_decode.sv
// DC302 microinstruction decode
// holds the IR, resolves register selects, builds the execute word

`timescale 1ns/1ps
`include "dc302_macros.svh"

module dc_micro_decode
(
   input  logic                pin_clk,
   input  logic                rst_n,
   input  dc302_pkg::dc_req_t  req,
   input  logic                take,
   output dc302_pkg::reg_sel_t sel_a,
   output dc302_pkg::reg_sel_t sel_b,
   input  dc302_pkg::word_t    opnd_a,
   input  dc302_pkg::word_t    opnd_b,
   output dc302_pkg::exec_t    ctl
);

   import dc302_pkg::*;

   localparam reg_sel_t sel_ir_src = reg_sel_t'(`DC_SEL_IR_SRC);
   localparam reg_sel_t sel_ir_dst = reg_sel_t'(`DC_SEL_IR_DST);

   word_t ir;        // PDP instruction register
   word_t imm;       // zero-extended 8-bit immediate
   logic  ld_ir;

   // codes 12 and 13 pick a register through IR fields
   function automatic reg_sel_t resolve(input reg_sel_t sel, input word_t ir_v);
      reg_sel_t idx;
      idx = sel;
      if (sel == sel_ir_src)
         idx = {1'b0, ir_v[8:6]};
      else if (sel == sel_ir_dst)
         idx = {1'b0, ir_v[2:0]};
      return idx;
   endfunction

   assign sel_a = resolve(req.ui.sel_a, ir);
   assign sel_b = resolve(req.ui.sel_b, ir);

   assign imm   = {{(`DC_WORD_W-8){1'b0}}, req.ui.sel_b, req.ui.cond};
   assign ld_ir = take && req.ui.op == op_ldir;

   always_ff @(posedge pin_clk or negedge rst_n)
   begin
      if (!rst_n)
         ir <= '0;
      else if (ld_ir)
         ir <= req.data;   // seen by the next accepted item
   end

   always_comb
   begin
      ctl.op     = req.ui.op;
      ctl.cond   = req.ui.cond;
      ctl.opnd_a = opnd_a;
      ctl.opnd_b = (req.ui.op == op_addi) ? imm : opnd_b;
      ctl.dst    = sel_a;   // port a is also the destination
      ctl.data   = req.data;
   end

endmodule

// File: logic/dc_pipe_stage.sv
// One-entry valid/ready pipeline register
// payload type is a parameter, loads when empty or draining

`timescale 1ns/1ps

module dc_pipe_stage
#(
   parameter type T = logic
)
(
   input  logic pin_clk,
   input  logic rst_n,
   input  T     in_data,
   input  logic in_valid,
   output logic in_ready,
   output T     out_data,
   output logic out_valid,
   input  logic out_ready
);

   logic full;    // entry holds an item
   T     data_q;

   assign in_ready  = ~full | out_ready;   // free now or free this edge
   assign out_valid = full;
   assign out_data  = data_q;

   always_ff @(posedge pin_clk or negedge rst_n)
   begin
      if (!rst_n)
         full <= 1'b0;
      else if (in_ready)
         full <= in_valid;
   end

   always_ff @(posedge pin_clk)
   begin
      if (in_valid && in_ready)
         data_q <= in_data;
   end

   // a stalled item stays put until the consumer takes it
   a_stall_hold: assert property (@(posedge pin_clk) disable iff (!rst_n)
      full && !out_ready |=> full && $stable(out_data));

endmodule

// File: logic/dc_regfile.sv
// DC302 16 x 16 register file
// two read ports with write bypass, one write port, PSW in slot 8

`timescale 1ns/1ps
`include "dc302_macros.svh"

module dc_regfile
(
   input  logic                pin_clk,
   input  logic                rst_n,
   input  dc302_pkg::reg_sel_t sel_a,
   input  dc302_pkg::reg_sel_t sel_b,
   output dc302_pkg::word_t    opnd_a,
   output dc302_pkg::word_t    opnd_b,
   output dc302_pkg::word_t    psw,
   input  dc302_pkg::wb_t      wb,
   input  logic                wb_take
);

   import dc302_pkg::*;

   localparam reg_sel_t psw_idx  = reg_sel_t'(`DC_PSW_REG);
   localparam word_t    psw_rsvd = 16'h0700;   // bits 10..8 always zero

   word_t regs [`DC_REG_N];
   word_t psw_nxt;    // psw after this edge
   logic  wr_data;    // data write on this edge

   assign wr_data = wb_take & wb.we;
   assign psw     = regs[`DC_PSW_REG];   // committed flags for execute

   always_comb
   begin
      psw_nxt = regs[`DC_PSW_REG];
      if (wr_data && wb.dst == psw_idx)
         psw_nxt = wb.data & ~psw_rsvd;
      // flags land on top of a data write
      if (wb_take && wb.fe)
         psw_nxt[3:0] = wb.flags;
   end

   // read with bypass of the write that commits on this edge
   function automatic word_t rd(input reg_sel_t sel);
      word_t val;
      val = regs[sel];
      if (sel == psw_idx)
         val = psw_nxt;
      else if (wr_data && wb.dst == sel)
         val = wb.data;
      return val;
   endfunction

   always_comb
   begin
      opnd_a = rd(sel_a);
      opnd_b = rd(sel_b);
   end

   always_ff @(posedge pin_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < `DC_REG_N; i++)
            regs[i] <= (i == `DC_PSW_REG) ? `DC_PSW_RESET : `DC_REG_RESET;
      end
      else
      begin
         if (wr_data && wb.dst != psw_idx)
            regs[wb.dst] <= wb.data;
         regs[`DC_PSW_REG] <= psw_nxt;   // unchanged unless written
      end
   end

   a_psw_rsvd: assert property (@(posedge pin_clk) disable iff (!rst_n)
      (regs[`DC_PSW_REG] & psw_rsvd) == '0);

endmodule

// File: run.sh
#!/bin/sh
# build and run the DC302 testbench with Verilator, then search the log
rm -f sim.log
verilator --binary --timing -Wno-fatal -f files.f --top-module tb_dc302 -o tb_dc302_sim \
   && ./obj_dir/tb_dc302_sim | tee sim.log \
   || echo "build or run did not complete"
grep -q "RESULT: PASS" sim.log && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

// File: test/tb_dc302.sv
// DC302 data path testbench
// directed tests against a reference model of registers, IR and PSW

`timescale 1ns/1ps
`include "dc302_macros.svh"

module tb_dc302;

   import dc302_pkg::*;

   localparam int wait_limit = 200;   // cycles per wait

   logic    pin_clk;
   logic    rst_n;
   dc_req_t req;
   logic    req_valid;
   logic    req_ready;
   result_t res;
   logic    res_valid;
   logic    res_ready;

   integer  seed = 32'h21cd_7392;
   integer  rdy_seed = 32'h21cd_7392;   // separate stream for res_ready
   logic    bp_en;
   logic    timed_out;                  // a wait ran out and later steps are skipped
   int      checks;
   int      mismatches;
   int      other_errs;

   word_t   m_regs [`DC_REG_N];   // reference registers with the PSW in slot 8
   word_t   m_ir;
   result_t exp_q [$];            // results in issue order
   result_t exp_now;

   dc302_datapath dc302_datapath_inst
   (
      .pin_clk   (pin_clk),
      .rst_n     (rst_n),
      .req       (req),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .res       (res),
      .res_valid (res_valid),
      .res_ready (res_ready)
   );

   always #10 pin_clk = ~pin_clk;

   // random stalls on the result side
   always @(posedge pin_clk)
   begin
      #1;
      if (bp_en)
         res_ready = ($random(rdy_seed) & 3) != 0;
      else
         res_ready = 1'b1;
   end

   task automatic check_word(input string name, input word_t got, input word_t exp);
      checks++;
      if (got !== exp)
      begin
         mismatches++;
         $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_flags(input string name, input flags_t got, input flags_t exp);
      checks++;
      if (got !== exp)
      begin
         mismatches++;
         $display("Mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp)
      begin
         mismatches++;
         $display("Mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_sel(input string name, input reg_sel_t got, input reg_sel_t exp);
      checks++;
      if (got !== exp)
      begin
         mismatches++;
         $display("Mismatch at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
      end
   endtask

   // a transfer happens at the next rising edge
   always @(negedge pin_clk)
   begin
      if (rst_n && res_valid && res_ready)
      begin
         if (exp_q.size() == 0)
         begin
            other_errs++;
            $display("Error at %0t ns: a result arrived with no request outstanding", $time);
         end
         else
         begin
            exp_now = exp_q.pop_front();
            check_word("res.data", res.data, exp_now.data);
            check_flags("res.flags", res.flags, exp_now.flags);
            check_bit("res.branch", res.branch, exp_now.branch);
            check_sel("res.dst", res.dst, exp_now.dst);
         end
      end
   end

   task automatic report_timeout(input string why);
      other_errs++;
      timed_out = 1'b1;
      $display("Error at %0t ns: %s", $time, why);
   endtask

   function automatic dc_req_t build_req(input dc_op_t op, input logic [3:0] cond,
                                         input reg_sel_t sb, input reg_sel_t sa,
                                         input word_t d);
      dc_req_t r;
      r.ui.op    = op;
      r.ui.cond  = cond;
      r.ui.sel_b = sb;
      r.ui.sel_a = sa;
      r.data     = d;
      return r;
   endfunction

   function automatic word_t pick_word();
      return word_t'($random(seed));
   endfunction

   function automatic reg_sel_t pick_reg();
      return reg_sel_t'($unsigned($random(seed)) % 8);
   endfunction

   // small register set so that neighbours depend on each other
   function automatic reg_sel_t hazard_reg();
      int pick;
      pick = $unsigned($random(seed)) % 5;
      return (pick == 4) ? reg_sel_t'(`DC_PSW_REG) : reg_sel_t'(pick);
   endfunction

   function automatic reg_sel_t resolve_sel(input reg_sel_t sel);
      if (sel == reg_sel_t'(`DC_SEL_IR_SRC))
         return {1'b0, m_ir[8:6]};
      if (sel == reg_sel_t'(`DC_SEL_IR_DST))
         return {1'b0, m_ir[2:0]};
      return sel;
   endfunction

   // reference step in acceptance order
   task automatic model_step(input dc_req_t r, output result_t exp);
      reg_sel_t    ia;
      reg_sel_t    ib;
      word_t       a;
      word_t       b;
      word_t       d;
      flags_t      of;
      flags_t      nf;
      logic [16:0] s;
      ia = resolve_sel(r.ui.sel_a);
      ib = resolve_sel(r.ui.sel_b);
      a  = m_regs[ia];
      b  = m_regs[ib];
      if (r.ui.op == op_addi)
         b = {8'h00, r.ui.sel_b, r.ui.cond};
      of   = flags_t'(m_regs[`DC_PSW_REG][3:0]);
      nf.v = 1'b0;
      nf.c = of.c;
      case (r.ui.op)
         op_mov:  d = b;
         op_add,
         op_addi:
         begin
            s    = {1'b0, a} + {1'b0, b};
            d    = s[15:0];
            nf.c = s[16];
            nf.v = (a[15] == b[15]) && (d[15] != a[15]);
         end
         op_sub:
         begin
            d    = a - b;
            nf.c = a < b;   // borrow
            nf.v = (a[15] != b[15]) && (d[15] != a[15]);
         end
         op_and:  d = a & b;
         op_bic:  d = a & ~b;
         op_bis:  d = a | b;
         op_xor:  d = a ^ b;
         op_asr:
         begin
            d    = word_t'($signed(b) >>> 1);
            nf.c = b[0];
            nf.v = d[15] ^ nf.c;
         end
         op_ldx,
         op_ldir: d = r.data;
         default: d = a;
      endcase
      nf.n = d[15];
      nf.z = d == 16'h0000;
      case (r.ui.cond[2:0])
         3'd0:    exp.branch = nf.n;
         3'd1:    exp.branch = nf.z;
         3'd2:    exp.branch = nf.c;
         3'd3:    exp.branch = nf.v;
         3'd4:    exp.branch = of.n;
         3'd5:    exp.branch = of.z;
         3'd6:    exp.branch = of.c;
         default: exp.branch = 1'b1;
      endcase
      exp.data  = d;
      exp.flags = nf;
      exp.dst   = ia;
      if (r.ui.op == op_ldir)
         m_ir = r.data;
      else
      begin
         if (r.ui.op != op_tst)
         begin
            if (ia == reg_sel_t'(`DC_PSW_REG))
               m_regs[`DC_PSW_REG] = d & 16'hF8FF;   // bits 10..8 stay clear
            else
               m_regs[ia] = d;
         end
         m_regs[`DC_PSW_REG][3:0] = nf;
      end
   endtask

   // called 1 ns after a rising edge, returns 1 ns after the accepting edge
   task automatic send_req(input dc_req_t r);
      result_t exp;
      int      waited;
      if (!timed_out)
      begin
         req       = r;
         req_valid = 1'b1;
         waited    = 0;
         @(negedge pin_clk);
         while (!req_ready && waited < wait_limit)
         begin
            waited++;
            @(negedge pin_clk);
         end
         if (!req_ready)
         begin
            report_timeout("request was never accepted");
            req_valid = 1'b0;
         end
         else
         begin
            model_step(r, exp);
            exp_q.push_back(exp);
            @(posedge pin_clk);
            #1;
            req_valid = 1'b0;
         end
      end
   endtask

   task automatic wait_results();
      int waited;
      waited = 0;
      if (!timed_out)
      begin
         while (exp_q.size() != 0 && waited < wait_limit)
         begin
            waited++;
            @(posedge pin_clk);
         end
         if (exp_q.size() != 0)
            report_timeout("expected results never arrived");
         else
         begin
            repeat (3) @(posedge pin_clk);   // room for a stray extra result
            #1;
         end
      end
   endtask

   task automatic test_reset();
      int i;
      send_req(build_req(op_mov, 4'h7, 4'd8, 4'd8, 16'h0000));   // PSW before flags move
      for (i = 0; i < `DC_REG_N; i++)
      begin
         if (i != `DC_PSW_REG)
            send_req(build_req(op_mov, 4'h7, reg_sel_t'(i), reg_sel_t'(i), 16'h0000));
      end
      wait_results();
   endtask

   task automatic test_arith();
      int         i;
      logic [3:0] code;
      send_req(build_req(op_ldx, 4'h0, 4'd0, 4'd0, 16'h7FFF));
      send_req(build_req(op_ldx, 4'h0, 4'd0, 4'd1, 16'h0001));
      send_req(build_req(op_add, 4'h3, 4'd1, 4'd0, 16'h0000));   // signed overflow
      send_req(build_req(op_ldx, 4'h0, 4'd0, 4'd2, 16'hFFFF));
      send_req(build_req(op_add, 4'h2, 4'd1, 4'd2, 16'h0000));   // carry out, zero
      send_req(build_req(op_ldx, 4'h0, 4'd0, 4'd3, 16'h8000));
      send_req(build_req(op_sub, 4'h3, 4'd1, 4'd3, 16'h0000));
      send_req(build_req(op_ldx, 4'h0, 4'd0, 4'd4, 16'h0000));
      send_req(build_req(op_sub, 4'h2, 4'd1, 4'd4, 16'h0000));   // borrow
      send_req(build_req(op_addi, 4'hF, 4'hF, 4'd0, 16'h0000));
      for (i = 0; i < 8; i++)
         send_req(build_req(op_ldx, 4'h0, 4'd0, reg_sel_t'(i), pick_word()));
      for (i = 0; i < 24; i++)
      begin
         code = (i % 3 == 0) ? op_add : (i % 3 == 1) ? op_sub : op_addi;
         send_req(build_req(dc_op_t'(code), 4'($random(seed)), pick_reg(), pick_reg(),
                            16'h0000));
      end
      wait_results();
   endtask

   task automatic test_logic();
      int         i;
      logic [3:0] code;
      send_req(build_req(op_ldx, 4'h0, 4'd0, 4'd0, 16'hFFFF));
      send_req(build_req(op_ldx, 4'h0, 4'd0, 4'd1, 16'h0001));
      send_req(build_req(op_add, 4'h2, 4'd1, 4'd0, 16'h0000));   // c set
      for (i = 0; i < 30; i++)
      begin
         if (i == 15)
            send_req(build_req(op_sub, 4'h2, 4'd1, 4'd1, 16'h0000));   // c cleared
         if (i % 5 == 0)
            send_req(build_req(op_ldx, 4'h0, 4'd0, pick_reg(), pick_word()));
         code = 4'(3 + (i % 5));   // AND, BIC, BIS, XOR, ASR
         send_req(build_req(dc_op_t'(code), 4'($random(seed)), pick_reg(), pick_reg(),
                            16'h0000));
      end
      wait_results();
   endtask

   task automatic test_ir_select();
      int i;
      for (i = 0; i < 6; i++)
      begin
         send_req(build_req(op_ldir, 4'h0, 4'd0, 4'd0, pick_word()));
         send_req(build_req(op_ldx, 4'h0, 4'd0, 4'd13, pick_word()));
         send_req(build_req(op_add, 4'h1, 4'd13, 4'd12, 16'h0000));
         send_req(build_req(op_mov, 4'h0, 4'd12, 4'd13, 16'h0000));
         send_req(build_req(op_tst, 4'h4, 4'd0, 4'd12, 16'h0000));
      end
      wait_results();
   endtask

   task automatic test_branch();
      int c;
      for (c = 0; c < 16; c++)
      begin
         send_req(build_req(op_add, 4'(c), pick_reg(), pick_reg(), 16'h0000));
         send_req(build_req(op_tst, 4'(c), 4'd0, pick_reg(), 16'h0000));
      end
      wait_results();
   endtask

   task automatic test_backpressure();
      int         i;
      logic [3:0] code;
      bp_en = 1'b1;
      for (i = 0; i < 80; i++)
      begin
         code = 4'($unsigned($random(seed)) % 12);
         send_req(build_req(dc_op_t'(code), 4'($random(seed)), hazard_reg(), hazard_reg(),
                            pick_word()));
      end
      wait_results();
      bp_en = 1'b0;
   endtask

   initial
   begin
      pin_clk    = 1'b0;
      rst_n      = 1'b0;
      req        = '0;
      req_valid  = 1'b0;
      res_ready  = 1'b1;
      bp_en      = 1'b0;
      timed_out  = 1'b0;
      checks     = 0;
      mismatches = 0;
      other_errs = 0;
      m_ir       = '0;
      for (int i = 0; i < `DC_REG_N; i++)
         m_regs[i] = (i == `DC_PSW_REG) ? `DC_PSW_RESET : `DC_REG_RESET;
      repeat (16) @(posedge pin_clk);
      #1;
      rst_n = 1'b1;
      @(posedge pin_clk);
      #1;
      test_reset();
      test_arith();
      test_logic();
      test_ir_select();
      test_branch();
      test_backpressure();
      $display("%0d checks, %0d mismatches, %0d other errors", checks, mismatches, other_errs);
      if (mismatches == 0 && other_errs == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule
